// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_aud_play
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== aud_ctrl_pkg.sv ====
package aud_ctrl_pkg;

    // playback speed transform
    typedef enum logic [1:0] {
        MODE_NORMAL = 2'd0,  // one word per frame
        MODE_FAST   = 2'd1,  // address skips by speed
        MODE_HOLD   = 2'd2,  // word repeated speed frames
        MODE_LINEAR = 2'd3   // ramp prev -> cur
    } play_mode_e;

    typedef struct packed {
        play_mode_e            mode;   // 2 bits
        aud_types_pkg::speed_t speed;  // 3 bits
    } play_cfg_t;

    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,  // stopped, address at 0
        CTRL_PLAY  = 2'd1,  // ticks advance the address
        CTRL_PAUSE = 2'd2   // address and phase frozen
    } ctrl_state_e;

    // lrck edge finder in the dsp
    typedef enum logic [1:0] {
        DSP_WAIT_HI = 2'd0,  // lrck seen low, waiting for rise
        DSP_WAIT_LO = 2'd1   // waiting for lrck low
    } dsp_state_e;

    localparam play_cfg_t CFG_RESET = '{
        mode:  MODE_NORMAL,
        speed: aud_types_pkg::speed_t'(1)
    };

endpackage

// ==== aud_dsp.sv ====
`timescale 1ns/1ps

module aud_dsp (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_run,        // playing
    input  logic                       i_clear,      // rewind pulse
    input  aud_ctrl_pkg::play_cfg_t    i_cfg,
    input  logic                       i_daclrck,    // sampled as data only
    input  aud_types_pkg::sample_t     i_sram_data,  // word at o_sram_addr
    output aud_types_pkg::sram_addr_t  o_sram_addr,
    output aud_types_pkg::sample_t     o_sample      // changes only at ticks
);

    aud_ctrl_pkg::dsp_state_e  state_r, state_w;
    logic                      frame_edge;  // first high lrck cycle
    logic                      tick;        // frame edge while playing

    aud_types_pkg::sram_addr_t addr_r, addr_w;
    aud_types_pkg::sample_t    sample_r, sample_w;
    aud_types_pkg::sample_t    prev_r, prev_w;   // older word for linear
    aud_types_pkg::sample_t    cur_r, cur_w;     // held or newer word
    aud_types_pkg::frac_t      phase_r, phase_w;

    aud_types_pkg::speed_t     spd_eff;     // speed with 0 mapped to 1
    aud_types_pkg::frac_t      phase_nxt;   // wraps at spd_eff
    logic                      blk_start;   // phase 0 of a slow block

    // linear interpolation path
    aud_types_pkg::sample_t    lin_prev, lin_cur;
    aud_types_pkg::wgt_t       w_div, w_cur, w_prev;
    aud_types_pkg::acc_t       lin_num, lin_quot;
    aud_types_pkg::sample_t    lin_out;

    assign o_sram_addr = addr_r;
    assign o_sample    = sample_r;

    // lrck edge finder, needs a low before each rise
    always_comb begin
        state_w    = state_r;
        frame_edge = 1'b0;
        case (state_r)
            aud_ctrl_pkg::DSP_WAIT_LO: begin
                if (!i_daclrck) state_w = aud_ctrl_pkg::DSP_WAIT_HI;
            end
            aud_ctrl_pkg::DSP_WAIT_HI: begin
                if (i_daclrck) begin
                    state_w    = aud_ctrl_pkg::DSP_WAIT_LO;
                    frame_edge = 1'b1;
                end
            end
            default: state_w = aud_ctrl_pkg::DSP_WAIT_LO;
        endcase
    end

    assign tick = frame_edge && i_run;

    assign spd_eff   = (i_cfg.speed == '0) ? aud_types_pkg::speed_t'(1) : i_cfg.speed;
    assign blk_start = (phase_r == '0);
    assign phase_nxt = (phase_r == aud_types_pkg::frac_t'(spd_eff - 1'b1)) ?
                       '0 : phase_r + 1'b1;

    // at phase 0 the registers shift before the average is formed
    assign lin_prev = blk_start ? cur_r : prev_r;
    assign lin_cur  = blk_start ? i_sram_data : cur_r;
    assign w_div    = aud_types_pkg::wgt_t'({2'b00, spd_eff});
    assign w_cur    = aud_types_pkg::wgt_t'({2'b00, phase_r});
    assign w_prev   = w_div - w_cur;                        // s - c
    assign lin_num  = lin_prev * w_prev + lin_cur * w_cur;  // all signed
    assign lin_quot = lin_num / w_div;                      // truncates toward 0
    assign lin_out  = aud_types_pkg::sample_t'(lin_quot);   // lies between prev and cur

    always_comb begin
        addr_w   = addr_r;
        sample_w = sample_r;
        prev_w   = prev_r;
        cur_w    = cur_r;
        phase_w  = phase_r;
        if (i_clear) begin                  // rewind, wins over a tick
            addr_w   = '0;
            phase_w  = '0;
            prev_w   = '0;
            cur_w    = '0;
            if (frame_edge) sample_w = '0;
        end else if (tick) begin
            case (i_cfg.mode)
                aud_ctrl_pkg::MODE_FAST: begin
                    sample_w = i_sram_data;
                    addr_w   = addr_r + aud_types_pkg::sram_addr_t'(spd_eff);
                end
                aud_ctrl_pkg::MODE_HOLD: begin
                    if (blk_start) begin
                        cur_w    = i_sram_data;
                        sample_w = i_sram_data;
                        addr_w   = addr_r + 1'b1;
                    end else begin
                        sample_w = cur_r;   // repeat held word
                    end
                    phase_w = phase_nxt;
                end
                aud_ctrl_pkg::MODE_LINEAR: begin
                    if (blk_start) begin
                        prev_w = cur_r;
                        cur_w  = i_sram_data;
                        addr_w = addr_r + 1'b1;
                    end
                    sample_w = lin_out;
                    phase_w  = phase_nxt;
                end
                default: begin              // normal
                    sample_w = i_sram_data;
                    addr_w   = addr_r + 1'b1;
                end
            endcase
        end else if (frame_edge) begin
            sample_w = '0;                  // idle or paused frame
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r  <= aud_ctrl_pkg::DSP_WAIT_LO;
            addr_r   <= '0;
            sample_r <= '0;
            phase_r  <= '0;
        end else begin
            state_r  <= state_w;
            addr_r   <= addr_w;
            sample_r <= sample_w;
            phase_r  <= phase_w;
        end
    end

    // history words, start from 0 via clear
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            prev_r <= '0;
            cur_r  <= '0;
        end else begin
            prev_r <= prev_w;
            cur_r  <= cur_w;
        end
    end

endmodule

// ==== aud_dsp_props.sv ====
`timescale 1ns/1ps

module aud_dsp_props (
    input logic                       i_clk,
    input logic                       i_rst_n,
    input logic                       i_run,         // from the controller
    input logic                       i_clear,       // from the controller
    input logic                       i_frame_edge,  // first high lrck cycle
    input logic                       i_tick,        // frame edge while playing
    input aud_types_pkg::sram_addr_t  i_addr,
    input aud_types_pkg::sample_t     i_sample
);

    // address moves only on a playing tick or a rewind
    addr_hold_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_tick || i_clear) |=> $stable(i_addr))
        else $error("sram address changed without a tick or a clear");

    // a clear that ends playback keeps run low one more cycle
    run_clear_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_clear && $past(i_run)) |=> !i_run)
        else $error("run high in the cycle after a clear that ended playback");

    // idle or paused frame sends silence
    pause_zero_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_frame_edge && !i_run) |=> (i_sample == '0))
        else $error("sample not zero after a frame without run");

endmodule

bind aud_dsp aud_dsp_props u_props (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_run        (i_run),
    .i_clear      (i_clear),
    .i_frame_edge (frame_edge),
    .i_tick       (tick),
    .i_addr       (addr_r),
    .i_sample     (sample_r)
);

// ==== aud_i2s_tx.sv ====
`timescale 1ns/1ps

module aud_i2s_tx (
    input  logic                    i_clk,      // codec bit clock
    input  logic                    i_rst_n,
    input  logic                    i_daclrck,  // frame clock from codec
    input  aud_types_pkg::sample_t  i_sample,   // stable across the frame
    output logic                    o_dacdat
);

    logic                     lrck_q;      // lrck one cycle back
    logic                     lrck_fall;   // left half begins
    logic                     lrck_rise;   // right half begins
    aud_types_pkg::sample_t   word_r;      // word for both halves
    aud_types_pkg::sample_t   shift_r;     // msb goes out first
    aud_types_pkg::bit_cnt_t  bits_r;      // bits still to send

    assign lrck_fall = lrck_q && !i_daclrck;
    assign lrck_rise = !lrck_q && i_daclrck;

    // zero once the word is out
    assign o_dacdat = (bits_r != '0) && shift_r[aud_types_pkg::SAMPLE_W-1];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            lrck_q <= 1'b1;   // first event seen is a fall
            bits_r <= '0;
        end else begin
            lrck_q <= i_daclrck;
            if (lrck_fall || lrck_rise) begin
                bits_r <= aud_types_pkg::bit_cnt_t'(aud_types_pkg::SAMPLE_W);
            end else if (bits_r != '0) begin
                bits_r <= bits_r - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (lrck_fall) begin
            word_r  <= i_sample;      // capture at start of left half
            shift_r <= i_sample;
        end else if (lrck_rise) begin
            shift_r <= word_r;        // same word in right half
        end else begin
            shift_r <= shift_r << 1;
        end
    end

endmodule

// ==== aud_play_ctrl.sv ====
`timescale 1ns/1ps

module aud_play_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_start,      // strobe
    input  logic                       i_pause,      // strobe
    input  logic                       i_stop,       // strobe
    input  aud_ctrl_pkg::play_mode_e   i_mode,       // sampled with start
    input  aud_types_pkg::speed_t      i_speed,      // sampled with start
    input  aud_types_pkg::sram_addr_t  i_end_addr,   // last valid word
    input  aud_types_pkg::sram_addr_t  i_sram_addr,  // current read address
    output logic                       o_run,
    output logic                       o_clear,
    output aud_ctrl_pkg::play_cfg_t    o_cfg,
    output logic                       o_done
);

    aud_ctrl_pkg::ctrl_state_e state_r, state_w;
    aud_ctrl_pkg::play_cfg_t   cfg_r, cfg_w;
    logic                      clear_r, clear_w;
    logic                      done_r, done_w;
    logic                      eof;  // address ran past the end

    assign eof     = (state_r == aud_ctrl_pkg::CTRL_PLAY) && (i_sram_addr > i_end_addr);
    assign o_run   = (state_r == aud_ctrl_pkg::CTRL_PLAY) && !clear_r;  // low during clear
    assign o_clear = clear_r;
    assign o_cfg   = cfg_r;
    assign o_done  = done_r;

    always_comb begin
        state_w = state_r;
        cfg_w   = cfg_r;
        clear_w = 1'b0;
        done_w  = 1'b0;
        if (i_stop) begin                         // stop beats everything
            state_w = aud_ctrl_pkg::CTRL_IDLE;
            clear_w = 1'b1;
        end else if (eof) begin                   // end of file acts like stop
            state_w = aud_ctrl_pkg::CTRL_IDLE;
            clear_w = 1'b1;
            done_w  = 1'b1;
        end else if (i_pause) begin
            if (state_r == aud_ctrl_pkg::CTRL_PLAY) begin
                state_w = aud_ctrl_pkg::CTRL_PAUSE;
            end
        end else if (i_start) begin
            case (state_r)
                aud_ctrl_pkg::CTRL_IDLE: begin    // fresh start
                    state_w    = aud_ctrl_pkg::CTRL_PLAY;
                    clear_w    = 1'b1;            // rewind addr and phase
                    cfg_w.mode  = i_mode;
                    cfg_w.speed = i_speed;
                end
                aud_ctrl_pkg::CTRL_PAUSE: begin   // resume, keep old cfg
                    state_w = aud_ctrl_pkg::CTRL_PLAY;
                end
                default: begin                    // already playing
                    state_w = state_r;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r <= aud_ctrl_pkg::CTRL_IDLE;
            cfg_r   <= aud_ctrl_pkg::CFG_RESET;
            clear_r <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            state_r <= state_w;
            cfg_r   <= cfg_w;
            clear_r <= clear_w;
            done_r  <= done_w;
        end
    end

endmodule

// ==== aud_play_top.sv ====
`timescale 1ns/1ps

module aud_play_top (
    input  logic                       i_clk,        // codec bclk
    input  logic                       i_rst_n,
    input  logic                       i_start,
    input  logic                       i_pause,
    input  logic                       i_stop,
    input  aud_ctrl_pkg::play_mode_e   i_mode,
    input  aud_types_pkg::speed_t      i_speed,
    input  aud_types_pkg::sram_addr_t  i_end_addr,
    input  logic                       i_daclrck,    // codec frame clock
    input  aud_types_pkg::sample_t     i_sram_data,  // async sram read data
    output aud_types_pkg::sram_addr_t  o_sram_addr,
    output logic                       o_dacdat,
    output logic                       o_done        // end of file pulse
);

    logic                      run;
    logic                      clear;
    aud_ctrl_pkg::play_cfg_t   cfg;
    aud_types_pkg::sample_t    sample;

    aud_play_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .i_mode      (i_mode),
        .i_speed     (i_speed),
        .i_end_addr  (i_end_addr),
        .i_sram_addr (o_sram_addr),  // eof compare
        .o_run       (run),
        .o_clear     (clear),
        .o_cfg       (cfg),
        .o_done      (o_done)
    );

    aud_dsp u_dsp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_run       (run),
        .i_clear     (clear),
        .i_cfg       (cfg),
        .i_daclrck   (i_daclrck),
        .i_sram_data (i_sram_data),
        .o_sram_addr (o_sram_addr),
        .o_sample    (sample)
    );

    aud_i2s_tx u_i2s (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_daclrck (i_daclrck),
        .i_sample  (sample),
        .o_dacdat  (o_dacdat)
    );

endmodule

// ==== aud_types_pkg.sv ====
package aud_types_pkg;

    localparam int SAMPLE_W  = 16;                    // audio word width
    localparam int ADDR_W    = 20;                    // sram word address width
    localparam int SPEED_W   = 3;                     // speed field width

    localparam int WGT_W     = SPEED_W + 2;           // signed weight incl. sign and margin
    localparam int ACC_W     = SAMPLE_W + WGT_W;      // weighted sum before the divide
    localparam int BIT_CNT_W = $clog2(SAMPLE_W + 1);  // counts 0..SAMPLE_W

    typedef logic signed [SAMPLE_W-1:0] sample_t;     // mono pcm sample
    typedef logic [ADDR_W-1:0]          sram_addr_t;  // sram word address
    typedef logic [SPEED_W-1:0]         speed_t;      // 0 behaves as 1
    typedef logic [SPEED_W-1:0]         frac_t;       // phase inside a slow block

    // interpolation arithmetic
    typedef logic signed [WGT_W-1:0]    wgt_t;        // s-c, c and s as signed
    typedef logic signed [ACC_W-1:0]    acc_t;        // prev*(s-c) + cur*c

    typedef logic [BIT_CNT_W-1:0]       bit_cnt_t;    // serializer bits left

endpackage

// ==== compile.f ====
aud_types_pkg.sv
aud_ctrl_pkg.sv
aud_play_ctrl.sv
aud_dsp.sv
aud_i2s_tx.sv
aud_play_top.sv
aud_dsp_props.sv
tb_aud_play.sv

// ==== tb_aud_play.sv ====
`timescale 1ns/1ps

module tb_aud_play;

    localparam int HALF_CYC  = 32;                               // bit clocks per lrck half
    localparam int TBL_DEPTH = 256;
    localparam int NO_END    = (1 << aud_types_pkg::ADDR_W) - 1; // end address never reached

    logic                       clk;
    logic                       rst_n;
    logic                       start, pause, stop;
    aud_ctrl_pkg::play_mode_e   mode;
    aud_types_pkg::speed_t      speed;
    aud_types_pkg::sram_addr_t  end_addr;
    logic                       daclrck;
    aud_types_pkg::sample_t     sram_data;
    aud_types_pkg::sram_addr_t  sram_addr;
    logic                       dacdat;
    logic                       done;

    aud_types_pkg::sample_t     tbl [TBL_DEPTH];   // lcg words, sram backing
    aud_types_pkg::sample_t     rx_q [$];          // left-half words from the serial line
    aud_types_pkg::sample_t     rx_word;
    int                         lr_pos;            // bit clock index inside the frame
    int                         done_cnt;
    int                         check_cnt, err_cnt, tmo_cnt;

    aud_play_top u_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_start     (start),
        .i_pause     (pause),
        .i_stop      (stop),
        .i_mode      (mode),
        .i_speed     (speed),
        .i_end_addr  (end_addr),
        .i_daclrck   (daclrck),
        .i_sram_data (sram_data),
        .o_sram_addr (sram_addr),
        .o_dacdat    (dacdat),
        .o_done      (done)
    );

    always #50 clk = ~clk;  // 100 ns bit clock

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // upper address bits folded in, every address gets its own word
    function automatic aud_types_pkg::sample_t mem_word(input aud_types_pkg::sram_addr_t a);
        return tbl[a[7:0]] ^ aud_types_pkg::sample_t'({4'h0, a[19:8]});
    endfunction

    assign sram_data = mem_word(sram_addr);  // async sram read

    // word expected in frame n of a run started at address 0
    function automatic int expected_sample(input aud_ctrl_pkg::play_mode_e m,
                                           input int spd, input int n);
        int s, j, c, prv, cur, res;
        s = (spd == 0) ? 1 : spd;  // speed 0 acts as 1
        j = n / s;
        c = n % s;
        case (m)
            aud_ctrl_pkg::MODE_FAST: res = int'(mem_word(aud_types_pkg::sram_addr_t'(s * n)));
            aud_ctrl_pkg::MODE_HOLD: res = int'(mem_word(aud_types_pkg::sram_addr_t'(j)));
            aud_ctrl_pkg::MODE_LINEAR: begin
                prv = (j == 0) ? 0 : int'(mem_word(aud_types_pkg::sram_addr_t'(j - 1)));
                cur = int'(mem_word(aud_types_pkg::sram_addr_t'(j)));
                res = (prv * (s - c) + cur * c) / s;  // int divide truncates toward 0
            end
            default: res = int'(mem_word(aud_types_pkg::sram_addr_t'(n)));
        endcase
        return res;
    endfunction

    // lrck source and left-half receiver, msb first
    always @(negedge clk) begin
        if (lr_pos < aud_types_pkg::SAMPLE_W) begin
            rx_word = {rx_word[aud_types_pkg::SAMPLE_W-2:0], dacdat};
            if (lr_pos == aud_types_pkg::SAMPLE_W - 1) rx_q.push_back(rx_word);
        end
        lr_pos  = (lr_pos + 1) % (2 * HALF_CYC);
        daclrck = (lr_pos >= HALF_CYC);  // low half first
        if (done) done_cnt++;
    end

    task automatic wait_pos(input int p);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (lr_pos != p && n < 4 * HALF_CYC);
        if (lr_pos != p) begin
            tmo_cnt++;
            $display("timeout at %0t: frame position %0d never reached", $time, p);
        end
    endtask

    task automatic collect(input int n);
        int cyc;
        cyc = 0;
        while (rx_q.size() < n && cyc < (n + 2) * 2 * HALF_CYC) begin
            @(posedge clk);
            cyc++;
        end
        if (rx_q.size() < n) begin
            tmo_cnt++;
            $display("timeout at %0t: only %0d of %0d frames arrived", $time, rx_q.size(), n);
        end
    endtask

    task automatic start_cmd(input aud_ctrl_pkg::play_mode_e m, input int spd, input int last);
        @(negedge clk);
        mode     = m;
        speed    = aud_types_pkg::speed_t'(spd);
        end_addr = aud_types_pkg::sram_addr_t'(last);
        start    = 1'b1;
        @(negedge clk);
        start    = 1'b0;
    endtask

    task automatic ctl_cmd(input logic hold, input logic halt);
        @(negedge clk);
        pause = hold;
        stop  = halt;
        @(negedge clk);
        pause = 1'b0;
        stop  = 1'b0;
    endtask

    task automatic check_word(input int got, input int exp, input string what);
        check_cnt++;
        assert (got == exp) else begin
            err_cnt++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // stop, then start fresh so the word stream begins at frame 0
    task automatic restart(input aud_ctrl_pkg::play_mode_e m, input int spd, input int last);
        wait_pos(20);              // left half already received
        ctl_cmd(1'b0, 1'b1);
        wait_pos(24);
        rx_q.delete();
        start_cmd(m, spd, last);   // settles before the rise at 32
    endtask

    task automatic check_mode(input aud_ctrl_pkg::play_mode_e m, input int spd, input int n);
        int i;
        restart(m, spd, NO_END);
        collect(n);
        for (i = 0; i < n && i < rx_q.size(); i++) begin
            check_word(int'(rx_q[i]), expected_sample(m, spd, i),
                       $sformatf("%s x%0d frame %0d", m.name(), spd, i));
        end
    endtask

    initial begin
        logic [31:0] seed;
        int          i;
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        pause = 1'b0;
        stop = 1'b0;
        mode = aud_ctrl_pkg::MODE_NORMAL;
        speed = aud_types_pkg::speed_t'(1);
        end_addr = aud_types_pkg::sram_addr_t'(NO_END);
        daclrck = 1'b0;
        lr_pos = 0;
        rx_word = '0;
        done_cnt = 0;
        check_cnt = 0;
        err_cnt = 0;
        tmo_cnt = 0;
        seed = 32'h9863_bbef;
        for (i = 0; i < TBL_DEPTH; i++) begin
            seed   = lcg_next(seed);
            tbl[i] = aud_types_pkg::sample_t'(seed[31:16]);  // high bits, better spread
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        check_mode(aud_ctrl_pkg::MODE_NORMAL, 1, 8);
        check_mode(aud_ctrl_pkg::MODE_FAST, 3, 8);
        check_mode(aud_ctrl_pkg::MODE_HOLD, 4, 12);
        check_mode(aud_ctrl_pkg::MODE_LINEAR, 4, 12);

        // pause holds the address, frames go silent
        check_mode(aud_ctrl_pkg::MODE_NORMAL, 1, 4);
        wait_pos(20);
        rx_q.delete();
        ctl_cmd(1'b1, 1'b0);
        collect(2);
        for (i = 0; i < 2 && i < rx_q.size(); i++) begin
            check_word(int'(rx_q[i]), 0, $sformatf("paused frame %0d", i));
        end
        wait_pos(20);
        rx_q.delete();
        start_cmd(aud_ctrl_pkg::MODE_FAST, 3, NO_END);  // resume keeps normal x1
        collect(3);
        for (i = 0; i < 3 && i < rx_q.size(); i++) begin
            check_word(int'(rx_q[i]), expected_sample(aud_ctrl_pkg::MODE_NORMAL, 1, 4 + i),
                       $sformatf("resumed frame %0d", i));
        end
        check_mode(aud_ctrl_pkg::MODE_NORMAL, 1, 3);     // stop then start rewinds

        // end of file at address 20
        done_cnt = 0;
        restart(aud_ctrl_pkg::MODE_NORMAL, 1, 20);
        collect(24);
        for (i = 0; i < 24 && i < rx_q.size(); i++) begin
            check_word(int'(rx_q[i]),
                       (i <= 20) ? expected_sample(aud_ctrl_pkg::MODE_NORMAL, 1, i) : 0,
                       $sformatf("eof run frame %0d", i));
        end
        check_word(done_cnt, 1, "o_done pulse count");

        $display("checks: %0d  errors: %0d  timeouts: %0d", check_cnt, err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
